// ==== src/bist_pkg.sv ====
// shared sizes, controller state and mode enums, accumulator request and checker strobe structs
package bist_pkg;

    // array geometry
    localparam int LANES  = 8;
    localparam int PSUM_W = 19;   // 8b weight x 8b act + log2(8) growth
    localparam int ROW_W  = 3;
    localparam int ROWS   = 8;
    localparam int LANE_W = 3;

    // test lengths
    localparam int MBIST_PATTERNS = 8;
    localparam int SA_PATTERNS    = 12;
    localparam int PAT_W          = 4;   // wide enough for the 12 stuck-at patterns

    typedef logic [PSUM_W-1:0] psum_t;

    // one full accumulator row, lane 0 in the low bits
    typedef psum_t [LANES-1:0] lane_data_t;

    typedef enum logic {
        MBIST = 1'b0,
        LBIST = 1'b1
    } bist_mode_e;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        MB_WRITE   = 4'd1,
        MB_READ    = 4'd2,
        MB_CHECK   = 4'd3,
        SA_SHIFT   = 4'd4,
        SA_CAPTURE = 4'd5,
        SA_CHECK   = 4'd6,
        COMPLETE   = 4'd7,
        FAIL       = 4'd8
    } bist_state_e;

    // request bundle towards the accumulator bank
    typedef struct packed {
        logic             wr_en;
        logic             test_mode;
        logic [ROW_W-1:0] wr_addr;
        logic [ROW_W-1:0] rd_addr;   // data returns one cycle later
    } acc_req_t;

    // strobes shared by all lane checkers
    typedef struct packed {
        logic load_exp;
        logic check;
        logic clear;
    } check_ctl_t;

endpackage

// ==== src/mbist_pattern_gen.sv ====
// MBIST data pattern table indexed by the pattern counter
`timescale 1ns/1ns

module mbist_pattern_gen
    import bist_pkg::*;
(
    input  logic [PAT_W-1:0] pattern_idx,
    output psum_t            mb_data
);

    always_comb begin
        case (pattern_idx)
            0:       mb_data = '0;
            1:       mb_data = '1;
            2:       mb_data = psum_t'('h55555);   // checkerboard
            3:       mb_data = psum_t'('h2AAAA);   // inverse checkerboard
            4:       mb_data = psum_t'('h001FF);   // low 9 bits set
            5:       mb_data = ~psum_t'('h001FF);
            6:       mb_data = psum_t'('h49249);   // one bit in every three
            7:       mb_data = ~psum_t'('h49249);
            default: mb_data = '0;   // LBIST indices beyond the table
        endcase
    end

endmodule

// ==== src/lane_checker.sv ====
// per-lane expected value register, comparator and sticky fault bit
`timescale 1ns/1ns

module lane_checker
    import bist_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  check_ctl_t check_ctl,
    input  logic       exp_sel,
    input  psum_t      mb_data,
    input  psum_t      envm_answer,
    input  psum_t      lane_rd,
    output logic       hit,
    output logic       fault
);

    psum_t exp_q;

    always_ff @(posedge clk) begin
        if (check_ctl.load_exp) begin
            exp_q <= exp_sel ? envm_answer : mb_data;
        end
    end

    // lane_rd already carries the row addressed in the previous cycle
    assign hit = check_ctl.check && (lane_rd != exp_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (check_ctl.clear) begin
            fault <= 1'b0;
        end else if (hit) begin
            fault <= 1'b1;   // held until the next run
        end
    end

endmodule

// ==== src/fault_collect.sv ====
// lane hit reduction, first-hit fault vector and lowest failing lane
`timescale 1ns/1ns

module fault_collect
    import bist_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic [LANES-1:0]  hits,
    output logic              any_hit,
    output logic [LANES-1:0]  fault_lanes,
    output logic [LANE_W-1:0] fail_lane
);

    logic [LANE_W-1:0] low_lane;

    assign any_hit = |hits;

    // priority encoder, lowest index wins
    always_comb begin
        low_lane = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                low_lane = LANE_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_lanes <= '0;
            fail_lane   <= '0;
        end else if (clear) begin
            fault_lanes <= '0;
            fail_lane   <= '0;
        end else if (any_hit && (fault_lanes == '0)) begin
            // only the first failing check of a run is recorded
            fault_lanes <= hits;
            fail_lane   <= low_lane;
        end
    end

endmodule

// ==== src/bist_ctrl.sv ====
// BIST sequencing FSM with pattern and row counters and the start/done handshake
`timescale 1ns/1ns

module bist_ctrl
    import bist_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_req,
    input  logic             test_en,
    input  bist_mode_e       mode,
    input  logic             any_hit,
    output acc_req_t         acc_req,
    output logic             scan_en,
    output logic [PAT_W-1:0] pattern_idx,
    output check_ctl_t       check_ctl,
    output logic             exp_sel,
    output logic             test_done,
    output logic             test_pass
);

    bist_state_e      state;
    bist_state_e      next_state;
    bist_mode_e       mode_q;
    logic [PAT_W-1:0] pat_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             start_ok;
    logic             last_row;
    logic             last_mb_pat;
    logic             last_sa_pat;

    assign start_ok    = (state == IDLE) && start_req && test_en;
    assign last_row    = (row_cnt == ROW_W'(ROWS - 1));
    assign last_mb_pat = (pat_cnt == PAT_W'(MBIST_PATTERNS - 1));
    assign last_sa_pat = (pat_cnt == PAT_W'(SA_PATTERNS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_ok) begin
                    next_state = (mode == LBIST) ? SA_SHIFT : MB_WRITE;
                end
            end
            MB_WRITE: begin
                // whole bank is written before any row is read back
                if (last_row) begin
                    next_state = MB_READ;
                end
            end
            MB_READ:  next_state = MB_CHECK;
            MB_CHECK: begin
                if (any_hit) begin
                    next_state = FAIL;
                end else if (last_row && last_mb_pat) begin
                    next_state = COMPLETE;
                end else if (last_row) begin
                    next_state = MB_WRITE;   // on to the next pattern
                end else begin
                    next_state = MB_READ;
                end
            end
            SA_SHIFT:   next_state = SA_CAPTURE;
            SA_CAPTURE: next_state = SA_CHECK;
            SA_CHECK: begin
                if (any_hit) begin
                    next_state = FAIL;
                end else if (last_sa_pat) begin
                    next_state = COMPLETE;
                end else begin
                    next_state = SA_SHIFT;
                end
            end
            COMPLETE, FAIL: begin
                // hold the acknowledge until the request drops
                if (!start_req) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // counters freeze on a hit so pattern_idx points at the failing pattern
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q  <= MBIST;
            pat_cnt <= '0;
            row_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_ok) begin
                        mode_q  <= mode;   // mode sampled once per run
                        pat_cnt <= '0;
                        row_cnt <= '0;
                    end
                end
                MB_WRITE: begin
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                end
                MB_CHECK: begin
                    if (!any_hit) begin
                        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                        if (last_row && !last_mb_pat) begin
                            pat_cnt <= pat_cnt + 1'b1;
                        end
                    end
                end
                SA_CHECK: begin
                    if (!any_hit && !last_sa_pat) begin
                        pat_cnt <= pat_cnt + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        acc_req.wr_en     = (state == MB_WRITE);
        acc_req.test_mode = !(state inside {IDLE, COMPLETE, FAIL});
        acc_req.wr_addr   = row_cnt;
        // stuck-at results always land in row 0
        acc_req.rd_addr   = (state inside {SA_SHIFT, SA_CAPTURE, SA_CHECK}) ? '0 : row_cnt;

        check_ctl.load_exp = (state == MB_READ) || (state == SA_CAPTURE);
        check_ctl.check    = (state == MB_CHECK) || (state == SA_CHECK);
        check_ctl.clear    = start_ok;   // wipe old faults on the start edge

        scan_en     = (state == SA_SHIFT);
        pattern_idx = pat_cnt;
        exp_sel     = (mode_q == LBIST);   // 1 selects the eNVM answer
        test_done   = (state == COMPLETE) || (state == FAIL);
        test_pass   = (state == COMPLETE);
    end

endmodule

// ==== src/acc_bist_top.sv ====
// accumulator BIST top with controller, pattern generator, lane checkers and fault collector
`timescale 1ns/1ns

module acc_bist_top
    import bist_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_req,
    input  logic              test_en,
    input  bist_mode_e        mode,
    input  psum_t             envm_answer,
    input  lane_data_t        acc_rd_data,
    output acc_req_t          acc_req,
    output lane_data_t        acc_wr_data,
    output logic              scan_en,
    output logic [PAT_W-1:0]  pattern_idx,
    output logic              test_done,
    output logic              test_pass,
    output logic [LANES-1:0]  fault_lanes,
    output logic [LANE_W-1:0] fail_lane
);

    check_ctl_t       check_ctl;
    logic             exp_sel;
    logic             any_hit;
    psum_t            mb_data;
    logic [LANES-1:0] lane_hit;
    logic [LANES-1:0] lane_fault;

    bist_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req   (start_req),
        .test_en     (test_en),
        .mode        (mode),
        .any_hit     (any_hit),
        .acc_req     (acc_req),
        .scan_en     (scan_en),
        .pattern_idx (pattern_idx),
        .check_ctl   (check_ctl),
        .exp_sel     (exp_sel),
        .test_done   (test_done),
        .test_pass   (test_pass)
    );

    mbist_pattern_gen u_pat_gen (
        .pattern_idx (pattern_idx),
        .mb_data     (mb_data)
    );

    assign acc_wr_data = {LANES{mb_data}};   // same pattern in every lane

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_checker u_chk (
            .clk         (clk),
            .rst_n       (rst_n),
            .check_ctl   (check_ctl),
            .exp_sel     (exp_sel),
            .mb_data     (mb_data),
            .envm_answer (envm_answer),
            .lane_rd     (acc_rd_data[i]),
            .hit         (lane_hit[i]),
            .fault       (lane_fault[i])
        );
    end

    // latched lanes keep any_hit up until the next clear
    fault_collect u_collect (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (check_ctl.clear),
        .hits        (lane_hit | lane_fault),
        .any_hit     (any_hit),
        .fault_lanes (fault_lanes),
        .fail_lane   (fail_lane)
    );

endmodule

// ==== sim/acc_env_model.sv ====
// behavioral accumulator bank with registered read, stuck-bit injection and eNVM answer table
`timescale 1ns/1ns

module acc_env_model
    import bist_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  acc_req_t                  acc_req,
    input  lane_data_t                acc_wr_data,
    input  logic                      scan_en,
    input  logic [PAT_W-1:0]          pattern_idx,
    input  logic                      tab_we,
    input  logic [PAT_W-1:0]          tab_idx,
    input  psum_t                     tab_data,
    input  logic                      stuck_en,
    input  logic [ROW_W-1:0]          stuck_row,
    input  logic [LANE_W-1:0]         stuck_lane,
    input  logic [$clog2(PSUM_W)-1:0] stuck_bit,
    input  logic                      stuck_val,
    input  logic                      sa_en,
    input  logic [PAT_W-1:0]          sa_pat,
    input  logic [LANES-1:0]          sa_mask,
    output psum_t                     envm_answer,
    output lane_data_t                acc_rd_data
);

    lane_data_t bank [ROWS];
    psum_t      envm_tab [SA_PATTERNS];
    lane_data_t cap_row;
    logic       cap_q;   // high during the capture cycle

    function automatic lane_data_t apply_stuck(input lane_data_t d, input logic [ROW_W-1:0] row);
        lane_data_t r;
        r = d;
        if (stuck_en && row == stuck_row) begin
            r[stuck_lane][stuck_bit] = stuck_val;
        end
        return r;
    endfunction

    assign envm_answer = (pattern_idx < SA_PATTERNS) ? envm_tab[pattern_idx] : '0;

    // captured answer, masked lanes come back inverted
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            cap_row[i] = (sa_en && pattern_idx == sa_pat && sa_mask[i]) ? ~envm_answer
                                                                        : envm_answer;
        end
    end

    always_ff @(posedge clk) begin
        if (tab_we) begin
            envm_tab[tab_idx] <= tab_data;
        end
        if (acc_req.wr_en) begin
            bank[acc_req.wr_addr] <= acc_wr_data;
        end else if (cap_q) begin
            bank[0] <= cap_row;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_q       <= 1'b0;
            acc_rd_data <= '0;
        end else begin
            cap_q       <= scan_en;
            // capture result is forwarded to the read port in the same cycle
            acc_rd_data <= apply_stuck(cap_q ? cap_row : bank[acc_req.rd_addr], acc_req.rd_addr);
        end
    end

endmodule

// ==== sim/tb_acc_bist.sv ====
// testbench for acc_bist_top with data file cases, run sequencing and result checks
`timescale 1ns/1ns

module tb_acc_bist
    import bist_pkg::*;
();

    localparam int TIMEOUT_CYC = 400;
    localparam int RST_CYC     = 16;

    logic clk, rst_n, start_req, test_en, scan_en, test_done, test_pass;
    bist_mode_e        mode;
    psum_t             envm_answer;
    lane_data_t        acc_rd_data, acc_wr_data;
    acc_req_t          acc_req;
    logic [PAT_W-1:0]  pattern_idx;
    logic [LANES-1:0]  fault_lanes;
    logic [LANE_W-1:0] fail_lane;
    // fault injection and eNVM load controls for the model
    logic tab_we, stuck_en, stuck_val, sa_en;
    logic [PAT_W-1:0] tab_idx, sa_pat;
    psum_t tab_data;
    logic [ROW_W-1:0] stuck_row;
    logic [LANE_W-1:0] stuck_lane;
    logic [$clog2(PSUM_W)-1:0] stuck_bit;
    logic [LANES-1:0] sa_mask;

    logic [31:0] tdata [0:127];
    int err_cnt, check_cnt, timeout_cnt, run_cnt, scan_cnt, idx;
    int mode_lo_cnt;   // run cycles with test_mode low
    integer seed;

    acc_bist_top DUT (.*);

    acc_env_model u_env (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bit b of MBIST pattern p
    function automatic logic pat_bit(input int p, input int b);
        case (p)
            0: return 1'b0;
            1: return 1'b1;
            2: return (b % 2) == 0;
            3: return (b % 2) == 1;
            4: return b < PSUM_W / 2;
            5: return b >= PSUM_W / 2;
            6: return (b % 3) == 0;   // walking one every third bit
            default: return (b % 3) != 0;
        endcase
    endfunction

    function automatic int first_diff_pattern(input int b, input logic val);
        for (int p = 0; p < MBIST_PATTERNS; p++) begin
            if (pat_bit(p, b) != val) return p;
        end
        return -1;
    endfunction

    function automatic int lowest_lane(input logic [LANES-1:0] mask);
        for (int i = 0; i < LANES; i++) begin
            if (mask[i]) return i;
        end
        return 0;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_and_stop;
        $display("runs %0d, checks %0d, errors %0d, timeouts %0d",
                 run_cnt, check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // cycles counted from the last rising edge until test_done reaches level
    task automatic wait_done_level(input logic level, input string what, output int cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (test_done !== level && n < TIMEOUT_CYC) begin
            if (scan_en === 1'b1) scan_cnt++;
            if (acc_req.test_mode !== 1'b1) mode_lo_cnt++;
            @(negedge clk);
            n++;
        end
        cycles = n;
        if (test_done !== level) begin
            timeout_cnt++;
            $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYC);
            report_and_stop();
        end
    endtask

    task automatic start_run(input bist_mode_e m, output int cycles);
        @(posedge clk);
        start_req <= 1'b1;
        mode      <= m;
        @(posedge clk);   // start edge
        scan_cnt    = 0;
        mode_lo_cnt = 0;
        wait_done_level(1'b1, "test_done rise", cycles);
        run_cnt++;
        check_value(mode_lo_cnt, 0, "test_mode high through the run");
        check_value(acc_req.test_mode, 0, "test_mode low at done");
    endtask

    task automatic release_run;
        int n;
        repeat (1 + ($unsigned($random(seed)) % 4)) begin
            @(negedge clk);
            check_value(test_done, 1, "test_done held while start_req high");
        end
        @(posedge clk);
        start_req <= 1'b0;
        wait_done_level(1'b0, "test_done release", n);
        check_value(n <= 2, 1, "test_done falls within two cycles of release");
        repeat (2 + ($unsigned($random(seed)) % 6)) @(posedge clk);   // idle gap
    endtask

    task automatic mbist_case(input logic [31:0] en, row, lane, b, val);
        int cycles;
        @(posedge clk);
        {stuck_en, stuck_row, stuck_lane} <= {en[0], row[ROW_W-1:0], lane[LANE_W-1:0]};
        {stuck_bit, stuck_val, sa_en}     <= {b[$clog2(PSUM_W)-1:0], val[0], 1'b0};
        start_run(MBIST, cycles);
        if (!en[0]) begin
            check_value(cycles, MBIST_PATTERNS * 3 * ROWS, "clean MBIST cycles to done");
            check_value(test_pass, 1, "clean MBIST pass");
            check_value(fault_lanes, 0, "clean MBIST fault_lanes");
            check_value(fail_lane, 0, "clean MBIST fail_lane");
        end else begin
            check_value(test_pass, 0, "stuck MBIST pass");
            check_value(fault_lanes, 32'(1) << lane, "stuck MBIST fault_lanes");
            check_value(fail_lane, lane, "stuck MBIST fail_lane");
            check_value(pattern_idx, first_diff_pattern(b, val[0]), "stuck MBIST pattern");
        end
        release_run();
    endtask

    task automatic lbist_case(input logic [31:0] en, pat, mask);
        int cycles;
        @(posedge clk);
        {stuck_en, sa_en, sa_pat, sa_mask} <= {1'b0, en[0], pat[PAT_W-1:0], mask[LANES-1:0]};
        start_run(LBIST, cycles);
        if (!en[0]) begin
            check_value(cycles, 3 * SA_PATTERNS, "clean LBIST cycles to done");
            check_value(test_pass, 1, "clean LBIST pass");
            check_value(scan_cnt, SA_PATTERNS, "scan_en pulses");
            check_value({fault_lanes, fail_lane}, 0, "clean LBIST fault outputs");
        end else begin
            check_value(test_pass, 0, "faulty LBIST pass");
            check_value(pattern_idx, pat, "faulty LBIST pattern");
            check_value(fault_lanes, mask, "faulty LBIST fault_lanes");
            check_value(fail_lane, lowest_lane(mask[LANES-1:0]), "faulty LBIST fail_lane");
        end
        release_run();
    endtask

    // request held with test_en low must not start anything
    task automatic gating_check;
        @(posedge clk);
        test_en   <= 1'b0;
        start_req <= 1'b1;
        mode      <= MBIST;
        repeat (50) begin
            @(negedge clk);
            check_value(test_done, 0, "test_done with test_en low");
            check_value(acc_req.wr_en, 0, "wr_en with test_en low");
            check_value(acc_req.test_mode, 0, "test_mode with test_en low");
        end
        @(posedge clk);
        start_req <= 1'b0;
        @(posedge clk);
        test_en <= 1'b1;
    endtask

    initial begin
        seed = 46;
        {err_cnt, check_cnt, timeout_cnt, run_cnt, scan_cnt} = '0;
        mode_lo_cnt = 0;
        {rst_n, start_req, test_en} = 3'b000;
        mode = MBIST;
        {tab_we, tab_idx, tab_data, stuck_en, stuck_row, stuck_lane} = '0;
        {stuck_bit, stuck_val, sa_en, sa_pat, sa_mask} = '0;
        $readmemh("sim/acc_bist_testdata.txt", tdata);
        if (tdata[0] === 32'hx) begin
            err_cnt++;
            $display("test data file sim/acc_bist_testdata.txt is missing or empty");
        end
        // eNVM table is loaded while reset is held
        for (int i = 0; i < RST_CYC - 1; i++) begin
            @(posedge clk);
            tab_we   <= (i < SA_PATTERNS);
            tab_idx  <= PAT_W'(i);
            tab_data <= psum_t'(tdata[i]);
        end
        @(negedge clk);
        check_value({test_done, test_pass, scan_en, acc_req.wr_en, acc_req.test_mode}, 0,
                    "outputs in reset");
        check_value({fault_lanes, fail_lane}, 0, "fault outputs in reset");
        @(posedge clk);
        {rst_n, tab_we} <= {1'b1, 1'b0};
        gating_check();
        idx = SA_PATTERNS;
        while (tdata[idx] !== 32'hF && idx < 120) begin
            if (tdata[idx] === 32'h1) begin
                mbist_case(tdata[idx+1], tdata[idx+2], tdata[idx+3], tdata[idx+4], tdata[idx+5]);
                idx += 6;
            end else if (tdata[idx] === 32'h2) begin
                lbist_case(tdata[idx+1], tdata[idx+2], tdata[idx+3]);
                idx += 4;
            end else begin
                err_cnt++;
                $display("unknown case tag %0h at word %0d of the test data", tdata[idx], idx);
                idx = 120;
            end
        end
        report_and_stop();
    end

endmodule

// ==== acc_bist.f ====
src/bist_pkg.sv
src/mbist_pattern_gen.sv
src/lane_checker.sv
src/fault_collect.sv
src/bist_ctrl.sv
src/acc_bist_top.sv
sim/acc_env_model.sv
sim/tb_acc_bist.sv

// ==== Bender.yml ====
package:
  name: acc_bist

sources:
  - src/bist_pkg.sv
  - src/mbist_pattern_gen.sv
  - src/lane_checker.sv
  - src/fault_collect.sv
  - src/bist_ctrl.sv
  - src/acc_bist_top.sv
  - target: simulation
    files:
      - sim/acc_env_model.sv
      - sim/tb_acc_bist.sv

// ==== sim/acc_bist_testdata.txt ====
// words 0-11: eNVM answer per stuck-at pattern (hex, 19 bits)
// cases: 1 stuck_en row lane bit value | 2 fault_en pattern lane_mask | f ends
0A3C5
7FFFF
00000
12345
5A5A5
2F0F0
40001
3C3C3
1B6DB
6E249
00FFF
55AA5
// clean MBIST
1 0 0 0 0 0
// row 3 lane 5 bit 7 stuck at 1
1 1 3 5 7 1
// row 6 lane 2 bit 18 stuck at 0
1 1 6 2 12 0
// clean LBIST
2 0 0 00
// pattern 5, lanes 2 and 5 capture wrong
2 1 5 24
// pattern 11, lanes 0 and 7 capture wrong
2 1 b 81
// row 0 lane 0 bit 0 stuck at 1
1 1 0 0 0 1
// clean runs after the faulty ones
1 0 0 0 0 0
2 0 0 00
f
